/* Bender.yml */
package:
  name: wave_gen

sources:
  # package first, then leaf modules, then the top level
  - src/wave_pkg.sv
  - src/tri_ramp_gen.sv
  - src/sine_shaper.sv
  - src/square_shaper.sv
  - src/wave_select.sv
  - src/wave_gen_top.sv

  # testbench, top module wave_gen_tb
  - target: test
    files:
      - verification/wave_gen_tb.sv

/* files.f */
src/wave_pkg.sv
src/tri_ramp_gen.sv
src/sine_shaper.sv
src/square_shaper.sv
src/wave_select.sv
src/wave_gen_top.sv
verification/wave_gen_tb.sv

/* src/sine_shaper.sv */
`default_nettype none

module sine_shaper import wave_pkg::*;
(
    input  ramp_state_t ramp,
    output sample_t     sine
);

    // Piecewise-linear sine converter, the way analog function generators
    // do it: the gain drops in steps as the triangle nears its peaks.
    // Each half wave is shaped on the magnitude, then the sign is put back.

    logic neg;          // ramp below zero
    mag_t mag;          // |ramp value|
    mag_t shaped;       // shaped magnitude

    assign neg = ramp.value[SAMPLE_W-1];
    assign mag = neg ? mag_t'(-ramp.value) : mag_t'(ramp.value);

    // --------------------
    // four segments
    // --------------------

    always_comb
    begin
        if (mag < mag_t'(SINE_KNEE_1))
        begin
            // gain ~1.47 near the crossing
            shaped = mag + (mag >> 1) - (mag >> 5);
        end
        else if (mag < mag_t'(SINE_KNEE_2))
        begin
            // gain ~0.94
            shaped = mag_t'(SINE_OFS_2) + mag - (mag >> 4);
        end
        else if (mag < mag_t'(SINE_KNEE_3))
        begin
            // gain ~0.56
            shaped = mag_t'(SINE_OFS_3) + (mag >> 1) + (mag >> 4);
        end
        else
        begin
            // gain ~0.16, flat top
            shaped = mag_t'(SINE_OFS_4) + (mag >> 3) + (mag >> 5);
        end
    end

    // --------------------
    // sign restore
    // --------------------

    // shaped stays well below 2^15 so the cast keeps it positive
    always_comb
    begin
        if (neg)
            sine = -sample_t'(shaped);      // negative half wave
        else
            sine = sample_t'(shaped);
    end

    // --------------------
    // checks
    // --------------------

    // sampled once per ramp update, when value and sine have settled
    a_sign_follows_ramp : assert property (
        @(negedge ramp.tick)
        (ramp.value != '0) |-> (sine[SAMPLE_W-1] == ramp.value[SAMPLE_W-1])
    ) else $error("sine sign differs from ramp %0d -> %0d", ramp.value, sine);

endmodule

`default_nettype wire

/* src/square_shaper.sv */
`default_nettype none

module square_shaper import wave_pkg::*;
(
    input  ramp_state_t ramp,
    output sample_t     square
);

    logic above;        // ramp at or over +DEAD_BAND
    logic below;        // ramp at or under -DEAD_BAND

    // signed compares, both ends inclusive
    assign above = (ramp.value >= DEAD_BAND);
    assign below = (ramp.value <= -DEAD_BAND);

    // --------------------
    // slicer
    // --------------------

    // zero inside the band so the edge cannot chatter near the crossing
    always_comb
    begin
        if (above)
            square = sample_t'(AMPLITUDE);
        else if (below)
            square = sample_t'(-AMPLITUDE);
        else
            square = '0;                    // dead band
    end

endmodule

`default_nettype wire

/* src/tri_ramp_gen.sv */
`default_nettype none

module tri_ramp_gen import wave_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  octave_t     octave,
    output ramp_state_t ramp
);

    logic [DIV_W-1:0] div_cnt;      // sample-rate divider
    logic             div_wrap;     // last clock of a sample period
    sample_t          step;         // ramp increment for this octave
    ramp_state_t      ramp_q;

    // --------------------
    // sample-rate divider
    // --------------------

    assign div_wrap = (div_cnt == DIV_W'(SAMPLE_DIV - 1));

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            div_cnt <= '0;
        else if (div_wrap)
            div_cnt <= '0;                  // wrap to start the next period
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // each octave doubles the step, hence the frequency
    assign step = sample_t'(BASE_STEP << octave);

    // --------------------
    // triangle ramp
    // --------------------

    // turning points hold the value for one sample, only dir flips there
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ramp_q.value <= '0;
            ramp_q.dir   <= RAMP_UP;
            ramp_q.tick  <= 1'b0;
        end
        else
        begin
            ramp_q.tick <= div_wrap;        // high for one cycle after each update
            if (div_wrap)
            begin
                if (ramp_q.dir == RAMP_UP && ramp_q.value > AMPLITUDE)
                    ramp_q.dir <= RAMP_DOWN;            // top reached
                else if (ramp_q.dir == RAMP_DOWN && ramp_q.value < -AMPLITUDE)
                    ramp_q.dir <= RAMP_UP;              // bottom reached
                else if (ramp_q.dir == RAMP_UP)
                    ramp_q.value <= ramp_q.value + step;
                else
                    ramp_q.value <= ramp_q.value - step;
            end
        end
    end

    assign ramp = ramp_q;

    // --------------------
    // checks
    // --------------------

    // overshoot past the threshold is at most one step, even across octave changes
    a_ramp_bounded : assert property (
        @(posedge clk) disable iff (reset)
        (ramp_q.value <= RAMP_LIMIT) && (ramp_q.value >= -RAMP_LIMIT)
    ) else $error("ramp value %0d out of range", ramp_q.value);

    // ticks are a full sample period apart
    a_tick_single : assert property (
        @(posedge clk) disable iff (reset)
        ramp_q.tick |=> !ramp_q.tick
    ) else $error("tick high on two consecutive cycles");

endmodule

`default_nettype wire

/* src/wave_gen_top.sv */
`default_nettype none

module wave_gen_top import wave_pkg::*;
(
    input  wire       clk,
    input  wire       reset,
    input  wave_sel_e waveform,
    input  octave_t   octave,
    output sample_t   sample,
    output logic      sample_valid
);

    ramp_state_t ramp;      // shared triangle source
    sample_t     sine;
    sample_t     square;

    // --------------------
    // source
    // --------------------

    tri_ramp_gen u_ramp (
        .clk    (clk),
        .reset  (reset),
        .octave (octave),
        .ramp   (ramp)
    );

    // --------------------
    // shapers, combinational
    // --------------------

    sine_shaper u_sine (
        .ramp (ramp),
        .sine (sine)
    );

    square_shaper u_square (
        .ramp   (ramp),
        .square (square)
    );

    // registered output, one cycle after the ramp update
    wave_select u_select (
        .clk          (clk),
        .reset        (reset),
        .waveform     (waveform),
        .ramp         (ramp),
        .sine         (sine),
        .square       (square),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

endmodule

`default_nettype wire

/* src/wave_pkg.sv */
`default_nettype none

package wave_pkg;

    // --------------------
    // sample format
    // --------------------

    localparam int SAMPLE_W = 16;                   // audio sample width

    typedef logic signed [SAMPLE_W-1:0] sample_t;   // signed audio sample
    typedef logic        [SAMPLE_W-1:0] mag_t;      // unsigned magnitude of a sample

    // --------------------
    // timing and ramp
    // --------------------

    localparam int SAMPLE_DIV = 512;                // clocks per sample, ~97.6 kHz at 50 MHz
    localparam int DIV_W      = $clog2(SAMPLE_DIV); // divider counter width

    localparam int AMPLITUDE  = 21844;              // turning threshold, peak output
    localparam int BASE_STEP  = 393;                // ~440 Hz at octave 0
    localparam int OCTAVE_W   = 2;                  // 3 octaves up keeps the ramp in 16 bits

    // worst case step at the top octave, and how far the ramp may overshoot
    localparam int MAX_STEP   = BASE_STEP << ((1 << OCTAVE_W) - 1);
    localparam int RAMP_LIMIT = AMPLITUDE + MAX_STEP;

    typedef logic [OCTAVE_W-1:0] octave_t;          // step = BASE_STEP << octave

    // --------------------
    // shaper constants
    // --------------------

    localparam int DEAD_BAND  = AMPLITUDE >> 6;     // square zero band, 341

    // segment borders of the sine converter, built from shifts
    localparam int SINE_KNEE_1 = (AMPLITUDE >> 1) - (AMPLITUDE >> 4);  // 7/16
    localparam int SINE_KNEE_2 = (AMPLITUDE >> 1) + (AMPLITUDE >> 3);  // 5/8
    localparam int SINE_KNEE_3 = (AMPLITUDE >> 1) + (AMPLITUDE >> 2)
                               + (AMPLITUDE >> 4);                     // 13/16

    // offsets added in segments 2..4
    localparam int SINE_OFS_2 = AMPLITUDE >> 2;
    localparam int SINE_OFS_3 = AMPLITUDE >> 1;
    localparam int SINE_OFS_4 = AMPLITUDE - (AMPLITUDE >> 3) - (AMPLITUDE >> 5);

    // --------------------
    // opcodes and states
    // --------------------

    // one-hot waveform select, anything not listed means silence
    typedef enum logic [3:0] {
        WAVE_OFF      = 4'b0000,
        WAVE_SINE     = 4'b0001,
        WAVE_TRIANGLE = 4'b0010,
        WAVE_SQUARE   = 4'b0100
    } wave_sel_e;

    typedef enum logic {
        RAMP_UP,
        RAMP_DOWN
    } ramp_dir_e;

    typedef struct packed {
        sample_t   value;   // current triangle sample
        ramp_dir_e dir;     // slope direction
        logic      tick;    // value updated on the previous edge
    } ramp_state_t;

endpackage

`default_nettype wire

/* src/wave_select.sv */
`default_nettype none

module wave_select import wave_pkg::*;
(
    input  wire         clk,
    input  wire         reset,
    input  wave_sel_e   waveform,
    input  ramp_state_t ramp,
    input  sample_t     sine,
    input  sample_t     square,
    output sample_t     sample,
    output logic        sample_valid
);

    sample_t sel_sample;        // chosen waveform this cycle

    // --------------------
    // waveform mux
    // --------------------

    always_comb
    begin
        case (waveform)
            WAVE_SINE:     sel_sample = sine;
            WAVE_TRIANGLE: sel_sample = ramp.value;    // raw ramp
            WAVE_SQUARE:   sel_sample = square;
            default:       sel_sample = '0;            // off and illegal codes
        endcase
    end

    // --------------------
    // output register
    // --------------------

    // opcode is taken at the end of the tick cycle, the sample then holds
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            sample       <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            sample_valid <= ramp.tick;     // one-cycle strobe
            if (ramp.tick)
                sample <= sel_sample;
        end
    end

    // strobe lasts a single cycle, ticks from the ramp never come back to back
    a_valid_single : assert property (
        @(posedge clk) disable iff (reset)
        sample_valid |=> !sample_valid
    ) else $error("sample_valid high on two consecutive cycles");

endmodule

`default_nettype wire

/* verification/wave_gen_tb.sv */
`default_nettype none

module wave_gen_tb import wave_pkg::*;
();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_ROWS  = 12;    // extra rows from the xorshift generator
    localparam int FIXED_ROWS   = 13;

    // one row of stimulus, code kept raw so illegal opcodes fit
    typedef struct packed {
        logic [3:0] code;       // waveform opcode
        octave_t    octave;
        logic [9:0] count;      // samples to collect
    } stim_row_t;

    // --------------------
    // stimulus table
    // --------------------

    localparam stim_row_t FIXED_TABLE [FIXED_ROWS] = '{
        '{WAVE_TRIANGLE, 2'd0, 10'd460},    // two periods per octave
        '{WAVE_TRIANGLE, 2'd1, 10'd240},
        '{WAVE_TRIANGLE, 2'd2, 10'd120},
        '{WAVE_TRIANGLE, 2'd3, 10'd60},
        '{WAVE_SINE,     2'd0, 10'd240},    // all segment borders, both halves
        '{WAVE_SINE,     2'd1, 10'd120},
        '{WAVE_SINE,     2'd3, 10'd40},
        '{WAVE_SQUARE,   2'd1, 10'd120},
        '{WAVE_SQUARE,   2'd3, 10'd40},
        '{WAVE_OFF,      2'd2, 10'd20},
        '{4'b0011,       2'd0, 10'd20},     // illegal, two bits set
        '{4'b1000,       2'd3, 10'd20},     // illegal, unused bit
        '{4'b0110,       2'd1, 10'd20}
    };

    logic      clk;
    logic      reset;
    wave_sel_e waveform;
    octave_t   octave;
    sample_t   sample;
    logic      sample_valid;

    stim_row_t rows [$];            // fixed rows followed by random ones
    int        total_samples = 0;
    logic      table_ready   = 1'b0;
    int        cycle_cnt     = 0;   // posedges since start
    int        fail_count    = 0;

    // reference ramp state
    int        model_value = 0;
    logic      model_up    = 1'b1;

    wave_gen_top dut (
        .clk          (clk),
        .reset        (reset),
        .waveform     (waveform),
        .octave       (octave),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;     // read only at negedges

    // --------------------
    // reference model
    // --------------------

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one ramp update, a turning point holds the value for one sample
    task automatic advance_ramp(input int oct);
        int step;
        step = BASE_STEP << oct;
        if (model_up && model_value > AMPLITUDE)
            model_up = 1'b0;
        else if (!model_up && model_value < -AMPLITUDE)
            model_up = 1'b1;
        else if (model_up)
            model_value = model_value + step;
        else
            model_value = model_value - step;
    endtask

    // borders compared as exact fractions of the amplitude
    function automatic int shape_sine(input int v);
        int m;
        int s;
        m = (v < 0) ? -v : v;
        if (m * 16 < 7 * AMPLITUDE)
            s = m + m / 2 - m / 32;
        else if (m * 8 < 5 * AMPLITUDE)
            s = AMPLITUDE / 4 + m - m / 16;
        else if (m * 16 < 13 * AMPLITUDE)
            s = AMPLITUDE / 2 + m / 2 + m / 16;
        else
            s = AMPLITUDE - AMPLITUDE / 8 - AMPLITUDE / 32 + m / 8 + m / 32;
        return (v < 0) ? -s : s;
    endfunction

    function automatic int shape_square(input int v);
        if (v >= DEAD_BAND)
            return AMPLITUDE;
        else if (v <= -DEAD_BAND)
            return -AMPLITUDE;
        return 0;                       // dead band
    endfunction

    function automatic int expected_sample(input logic [3:0] code, input int v);
        case (code)
            WAVE_SINE:     return shape_sine(v);
            WAVE_TRIANGLE: return v;
            WAVE_SQUARE:   return shape_square(v);
            default:       return 0;    // off and every illegal code
        endcase
    endfunction

    // --------------------
    // compare tasks
    // --------------------

    task automatic check_sample(input sample_t got, input sample_t exp, input string what);
        if (got !== exp)
        begin
            fail_count++;
            $display("CHECK FAILED at %0t: %s, sample %0d expected %0d", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "sample mismatch");
        end
    endtask

    task automatic check_interval(input int got, input int exp, input string what);
        if (got != exp)
        begin
            fail_count++;
            $display("CHECK FAILED at %0t: %s, gap %0d cycles expected %0d",
                     $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "interval mismatch");
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            fail_count++;
            $display("CHECK FAILED at %0t: %s, sample_valid %b expected %b",
                     $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "strobe mismatch");
        end
    endtask

    // new levels go in on the edge after a strobe
    task automatic apply_row(input stim_row_t r);
        @(posedge clk);
        waveform <= wave_sel_e'(r.code);
        octave   <= r.octave;
    endtask

    task automatic wait_valid();
        @(negedge clk);
        while (!sample_valid)
            @(negedge clk);
    endtask

    // --------------------
    // watchdog
    // --------------------

    initial
    begin
        longint limit;
        wait (table_ready);
        limit = (longint'(total_samples) * SAMPLE_DIV * 2 + RESET_CYCLES) * CLK_PERIOD;
        #(limit);
        $display("watchdog expired at %0t, the simulation hung", $time);
        $display("TEST FAIL");
        $fatal(1, "simulation hung");
    end

    // --------------------
    // main sequence
    // --------------------

    initial
    begin
        logic [31:0] rng;
        stim_row_t   r;
        int          last_cnt;
        int          exp_gap;
        int          exp_val;
        string       what;

        reset    = 1'b1;
        waveform = WAVE_OFF;
        octave   = '0;

        // build the table, then random rows with illegal codes mixed in
        foreach (FIXED_TABLE[i])
            rows.push_back(FIXED_TABLE[i]);
        rng = 32'd16;
        for (int i = 0; i < RANDOM_ROWS; i++)
        begin
            rng = xorshift(rng);
            if (rng[31:30] != 2'b00)
                r.code = 4'b0001 << (rng[15:0] % 3);    // legal shape
            else
                r.code = rng[3:0];                      // any code
            r.octave = rng[9:8];
            r.count  = 10'(20 + (rng[27:12] % 41));
            rows.push_back(r);
        end
        foreach (rows[i])
            total_samples += rows[i].count;
        table_ready = 1'b1;

        apply_row(rows[0]);
        @(negedge clk);
        check_sample(sample, '0, "during reset");
        check_valid(sample_valid, 1'b0, "during reset");
        repeat (RESET_CYCLES - 1) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        last_cnt = cycle_cnt;           // count from the release edge
        exp_gap  = SAMPLE_DIV + 1;

        foreach (rows[i])
        begin
            for (int k = 0; k < rows[i].count; k++)
            begin
                wait_valid();
                what = $sformatf("row %0d sample %0d code %b octave %0d",
                                 i, k, rows[i].code, rows[i].octave);
                check_interval(cycle_cnt - last_cnt, exp_gap, what);
                last_cnt = cycle_cnt;
                exp_gap  = SAMPLE_DIV;
                advance_ramp(rows[i].octave);
                exp_val = expected_sample(rows[i].code, model_value);
                check_sample(sample, sample_t'(exp_val), what);
            end
            if (i + 1 < rows.size())
                apply_row(rows[i + 1]);
        end

        if (fail_count == 0)
        begin
            $display("TEST PASS");
            $finish;
        end
        else
        begin
            $display("TEST FAIL");
            $fatal(1, "%0d checks failed", fail_count);
        end
    end

endmodule

`default_nettype wire
